// File: project.f
+incdir+source
+incdir+verification
source/muldiv_pkg.sv
source/div_unit.sv
source/mul_unit.sv
source/muldiv_ctrl.sv
source/muldiv_top.sv
verification/muldiv_tb.sv

// File: run.sh
#!/bin/sh
# Build the muldiv testbench with Verilator, run it, and judge the log.
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert --top-module muldiv_tb -f project.f -o muldiv_sim

./obj_dir/muldiv_sim | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "=== PASS ===" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"

// File: source/div_unit.sv
`timescale 1ns/10ps
`include "muldiv_cfg.svh"

module div_unit (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    start_i,
    input  logic                    signed_i,
    input  muldiv_pkg::word_t       dividend_i,
    input  muldiv_pkg::word_t       divisor_i,
    output muldiv_pkg::div_result_t result_o,
    output logic                    done_o
);

    muldiv_pkg::div_state_e   state_r;
    logic [`MULDIV_CNT_W-1:0] cnt_r;
    logic [`MULDIV_XLEN:0]    rem_r;    // partial remainder, two's complement
    muldiv_pkg::word_t        quot_r;   // dividend bits out, quotient bits in
    muldiv_pkg::word_t        dvs_r;    // divisor magnitude
    logic                     signed_r;
    logic                     neg_quot_r;
    logic                     neg_rem_r;
    muldiv_pkg::div_result_t  result_r;
    logic                     done_r;

    logic                     dvd_neg;
    logic                     dvs_neg;
    muldiv_pkg::word_t        dvd_mag;
    muldiv_pkg::word_t        dvs_mag;
    logic                     div_zero;
    logic                     div_ovf;
    logic [`MULDIV_XLEN:0]    shl;
    logic [`MULDIV_XLEN:0]    step;
    muldiv_pkg::word_t        quot_shl;
    muldiv_pkg::word_t        rem_fix;

    always_comb begin
        dvd_neg  = signed_i & dividend_i[`MULDIV_XLEN-1];
        dvs_neg  = signed_i & divisor_i[`MULDIV_XLEN-1];
        dvd_mag  = dvd_neg ? -dividend_i : dividend_i;
        dvs_mag  = dvs_neg ? -divisor_i : divisor_i;
        div_zero = (divisor_i == '0);
        div_ovf  = signed_i && (dividend_i == {1'b1, {(`MULDIV_XLEN-1){1'b0}}})
                   && (divisor_i == '1);

        // shift next dividend bit into the remainder, then add or subtract
        shl  = {rem_r[`MULDIV_XLEN-1:0], quot_r[`MULDIV_XLEN-1]};
        step = rem_r[`MULDIV_XLEN] ? shl + {1'b0, dvs_r} : shl - {1'b0, dvs_r};

        // quotient bit of the previous step lands here
        quot_shl = {quot_r[`MULDIV_XLEN-2:0], ~rem_r[`MULDIV_XLEN]};
        rem_fix  = rem_r[`MULDIV_XLEN] ? rem_r[`MULDIV_XLEN-1:0] + dvs_r
                                       : rem_r[`MULDIV_XLEN-1:0];
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_r <= muldiv_pkg::DIV_IDLE;
            cnt_r   <= '0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state_r)
                muldiv_pkg::DIV_IDLE: begin
                    if (start_i) begin
                        if (div_zero || div_ovf) begin
                            done_r <= 1'b1;  // resolved at once
                        end else begin
                            cnt_r   <= `MULDIV_CNT_W'(`MULDIV_ITER);
                            state_r <= muldiv_pkg::DIV_ITER;
                        end
                    end
                end
                muldiv_pkg::DIV_ITER: begin
                    cnt_r <= cnt_r - 1'b1;
                    if (cnt_r == `MULDIV_CNT_W'(1)) begin
                        state_r <= muldiv_pkg::DIV_CORRECT;
                    end
                end
                muldiv_pkg::DIV_CORRECT: begin
                    if (signed_r) begin
                        state_r <= muldiv_pkg::DIV_SIGN;
                    end else begin
                        done_r  <= 1'b1;
                        state_r <= muldiv_pkg::DIV_IDLE;
                    end
                end
                muldiv_pkg::DIV_SIGN: begin
                    done_r  <= 1'b1;
                    state_r <= muldiv_pkg::DIV_IDLE;
                end
                default: state_r <= muldiv_pkg::DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_r)
            muldiv_pkg::DIV_IDLE: begin
                if (start_i) begin
                    rem_r      <= '0;
                    quot_r     <= dvd_mag;
                    dvs_r      <= dvs_mag;
                    signed_r   <= signed_i;
                    neg_quot_r <= dvd_neg ^ dvs_neg;
                    neg_rem_r  <= dvd_neg;  // remainder follows dividend
                    if (div_zero) begin
                        result_r.quot <= '1;
                        result_r.rem  <= dividend_i;
                    end else if (div_ovf) begin
                        result_r.quot <= dividend_i;
                        result_r.rem  <= '0;
                    end
                end
            end
            muldiv_pkg::DIV_ITER: begin
                rem_r  <= step;
                quot_r <= quot_shl;
            end
            muldiv_pkg::DIV_CORRECT: begin
                result_r.quot <= quot_shl;
                result_r.rem  <= rem_fix;
            end
            muldiv_pkg::DIV_SIGN: begin
                if (neg_quot_r) begin
                    result_r.quot <= -result_r.quot;
                end
                if (neg_rem_r) begin
                    result_r.rem <= -result_r.rem;
                end
            end
            default: ;
        endcase
    end

    assign result_o = result_r;
    assign done_o   = done_r;

    // the controller waits for done before the next start
    a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        start_i |-> state_r == muldiv_pkg::DIV_IDLE);

    a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_i)
        done_o |=> !done_o);

endmodule

// File: source/mul_unit.sv
`timescale 1ns/10ps
`include "muldiv_cfg.svh"

module mul_unit (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               start_i,
    input  logic               a_signed_i,
    input  logic               b_signed_i,
    input  muldiv_pkg::word_t  a_i,
    input  muldiv_pkg::word_t  b_i,
    output muldiv_pkg::dword_t product_o,
    output logic               done_o
);

    muldiv_pkg::mul_state_e   state_r;
    logic [`MULDIV_CNT_W-1:0] cnt_r;
    muldiv_pkg::dword_t       acc_r;
    muldiv_pkg::dword_t       mcand_r;   // shifts left each step
    muldiv_pkg::word_t        mplier_r;  // shifts right each step
    logic                     neg_r;
    logic                     done_r;

    logic                     a_neg;
    logic                     b_neg;
    muldiv_pkg::word_t        a_mag;
    muldiv_pkg::word_t        b_mag;

    always_comb begin
        a_neg = a_signed_i & a_i[`MULDIV_XLEN-1];
        b_neg = b_signed_i & b_i[`MULDIV_XLEN-1];
        a_mag = a_neg ? -a_i : a_i;
        b_mag = b_neg ? -b_i : b_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_r <= muldiv_pkg::MUL_IDLE;
            cnt_r   <= '0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (state_r)
                muldiv_pkg::MUL_IDLE: begin
                    if (start_i) begin
                        cnt_r   <= `MULDIV_CNT_W'(`MULDIV_ITER);
                        state_r <= muldiv_pkg::MUL_ITER;
                    end
                end
                muldiv_pkg::MUL_ITER: begin
                    cnt_r <= cnt_r - 1'b1;
                    if (cnt_r == `MULDIV_CNT_W'(1)) begin
                        if (neg_r) begin
                            state_r <= muldiv_pkg::MUL_SIGN;
                        end else begin
                            done_r  <= 1'b1;
                            state_r <= muldiv_pkg::MUL_IDLE;
                        end
                    end
                end
                muldiv_pkg::MUL_SIGN: begin
                    done_r  <= 1'b1;
                    state_r <= muldiv_pkg::MUL_IDLE;
                end
                default: state_r <= muldiv_pkg::MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_r)
            muldiv_pkg::MUL_IDLE: begin
                if (start_i) begin
                    acc_r    <= '0;
                    mcand_r  <= {{`MULDIV_XLEN{1'b0}}, a_mag};
                    mplier_r <= b_mag;
                    neg_r    <= a_neg ^ b_neg;
                end
            end
            muldiv_pkg::MUL_ITER: begin
                if (mplier_r[0]) begin
                    acc_r <= acc_r + mcand_r;
                end
                mcand_r  <= mcand_r << 1;
                mplier_r <= mplier_r >> 1;
            end
            muldiv_pkg::MUL_SIGN: acc_r <= -acc_r;
            default: ;
        endcase
    end

    assign product_o = acc_r;
    assign done_o    = done_r;

    a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_i)
        start_i |-> state_r == muldiv_pkg::MUL_IDLE);

endmodule

// File: source/muldiv_cfg.svh
`ifndef MULDIV_CFG_SVH
`define MULDIV_CFG_SVH

// operand width, fixed by the RV32 M opcodes
`define MULDIV_XLEN 32

// iteration counter, wide enough to hold MULDIV_ITER
`define MULDIV_CNT_W 6

// one quotient or multiplier bit per cycle
`define MULDIV_ITER 32

`endif

// File: source/muldiv_ctrl.sv
`timescale 1ns/10ps
`include "muldiv_cfg.svh"

module muldiv_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    req_i,
    input  muldiv_pkg::muldiv_req_t req_data_i,
    output logic                    ack_o,
    output muldiv_pkg::word_t       result_o,
    output logic                    div_start_o,
    output logic                    div_signed_o,
    output muldiv_pkg::word_t       div_dividend_o,
    output muldiv_pkg::word_t       div_divisor_o,
    input  muldiv_pkg::div_result_t div_result_i,
    input  logic                    div_done_i,
    output logic                    mul_start_o,
    output logic                    mul_a_signed_o,
    output logic                    mul_b_signed_o,
    output muldiv_pkg::word_t       mul_a_o,
    output muldiv_pkg::word_t       mul_b_o,
    input  muldiv_pkg::dword_t      product_i,
    input  logic                    mul_done_i
);

    muldiv_pkg::ctrl_state_e state_r;
    muldiv_pkg::muldiv_req_t req_r;
    logic                    use_div_r;
    logic                    div_start_r;
    logic                    mul_start_r;
    logic                    div_signed_r;
    logic                    mul_a_signed_r;
    logic                    mul_b_signed_r;
    logic                    ack_r;
    muldiv_pkg::word_t       result_r;

    logic                    dec_div;
    logic                    dec_div_signed;
    logic                    dec_a_signed;
    logic                    dec_b_signed;
    logic                    unit_done;
    muldiv_pkg::word_t       sel_word;

    // opcode decode on the incoming request
    always_comb begin
        dec_div        = 1'b0;
        dec_div_signed = 1'b0;
        dec_a_signed   = 1'b0;
        dec_b_signed   = 1'b0;
        case (req_data_i.op)
            muldiv_pkg::MULH: begin
                dec_a_signed = 1'b1;
                dec_b_signed = 1'b1;
            end
            muldiv_pkg::MULHSU: dec_a_signed = 1'b1;
            muldiv_pkg::DIV, muldiv_pkg::REM: begin
                dec_div        = 1'b1;
                dec_div_signed = 1'b1;
            end
            muldiv_pkg::DIVU, muldiv_pkg::REMU: dec_div = 1'b1;
            default: ;  // low half is the same signed or not
        endcase
    end

    always_comb begin
        unit_done = use_div_r ? div_done_i : mul_done_i;
        case (req_r.op)
            muldiv_pkg::MUL: sel_word = product_i[`MULDIV_XLEN-1:0];
            muldiv_pkg::MULH, muldiv_pkg::MULHSU, muldiv_pkg::MULHU:
                sel_word = product_i[2*`MULDIV_XLEN-1:`MULDIV_XLEN];
            muldiv_pkg::DIV, muldiv_pkg::DIVU: sel_word = div_result_i.quot;
            default: sel_word = div_result_i.rem;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_r     <= muldiv_pkg::CTRL_IDLE;
            div_start_r <= 1'b0;
            mul_start_r <= 1'b0;
            ack_r       <= 1'b0;
        end else begin
            div_start_r <= 1'b0;
            mul_start_r <= 1'b0;
            case (state_r)
                muldiv_pkg::CTRL_IDLE: begin
                    if (req_i) begin
                        div_start_r <= dec_div;
                        mul_start_r <= !dec_div;
                        state_r     <= muldiv_pkg::CTRL_BUSY;
                    end
                end
                muldiv_pkg::CTRL_BUSY: begin
                    if (unit_done) begin
                        ack_r   <= 1'b1;
                        state_r <= muldiv_pkg::CTRL_ACK;
                    end
                end
                muldiv_pkg::CTRL_ACK: begin
                    if (!req_i) begin  // requester done with the result
                        ack_r   <= 1'b0;
                        state_r <= muldiv_pkg::CTRL_IDLE;
                    end
                end
                default: state_r <= muldiv_pkg::CTRL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_r == muldiv_pkg::CTRL_IDLE && req_i) begin
            req_r          <= req_data_i;
            use_div_r      <= dec_div;
            div_signed_r   <= dec_div_signed;
            mul_a_signed_r <= dec_a_signed;
            mul_b_signed_r <= dec_b_signed;
        end
        if (state_r == muldiv_pkg::CTRL_BUSY && unit_done) begin
            result_r <= sel_word;
        end
    end

    assign ack_o          = ack_r;
    assign result_o       = result_r;
    assign div_start_o    = div_start_r;
    assign div_signed_o   = div_signed_r;
    assign div_dividend_o = req_r.a;
    assign div_divisor_o  = req_r.b;
    assign mul_start_o    = mul_start_r;
    assign mul_a_signed_o = mul_a_signed_r;
    assign mul_b_signed_o = mul_b_signed_r;
    assign mul_a_o        = req_r.a;
    assign mul_b_o        = req_r.b;

    // four-phase rule, ack holds until req is released
    a_ack_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        ack_o && req_i |=> ack_o);

endmodule

// File: source/muldiv_pkg.sv
`include "muldiv_cfg.svh"

package muldiv_pkg;

    typedef logic [`MULDIV_XLEN-1:0]   word_t;
    typedef logic [2*`MULDIV_XLEN-1:0] dword_t;

    // funct3 encoding
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } muldiv_op_e;

    typedef struct packed {
        muldiv_op_e op;
        word_t      a;
        word_t      b;
    } muldiv_req_t;

    typedef struct packed {
        word_t quot;
        word_t rem;
    } div_result_t;

    typedef enum logic [1:0] {DIV_IDLE, DIV_ITER, DIV_CORRECT, DIV_SIGN} div_state_e;
    typedef enum logic [1:0] {MUL_IDLE, MUL_ITER, MUL_SIGN} mul_state_e;
    typedef enum logic [1:0] {CTRL_IDLE, CTRL_BUSY, CTRL_ACK} ctrl_state_e;

endpackage

// File: source/muldiv_top.sv
`timescale 1ns/10ps
`include "muldiv_cfg.svh"

module muldiv_top (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    req_i,
    input  muldiv_pkg::muldiv_req_t req_data_i,
    output logic                    ack_o,
    output muldiv_pkg::word_t       result_o
);

    logic                    div_start;
    logic                    div_signed;
    muldiv_pkg::word_t       div_dividend;
    muldiv_pkg::word_t       div_divisor;
    muldiv_pkg::div_result_t div_result;
    logic                    div_done;
    logic                    mul_start;
    logic                    mul_a_signed;
    logic                    mul_b_signed;
    muldiv_pkg::word_t       mul_a;
    muldiv_pkg::word_t       mul_b;
    muldiv_pkg::dword_t      product;
    logic                    mul_done;

    muldiv_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .req_i          (req_i),
        .req_data_i     (req_data_i),
        .ack_o          (ack_o),
        .result_o       (result_o),
        .div_start_o    (div_start),
        .div_signed_o   (div_signed),
        .div_dividend_o (div_dividend),
        .div_divisor_o  (div_divisor),
        .div_result_i   (div_result),
        .div_done_i     (div_done),
        .mul_start_o    (mul_start),
        .mul_a_signed_o (mul_a_signed),
        .mul_b_signed_o (mul_b_signed),
        .mul_a_o        (mul_a),
        .mul_b_o        (mul_b),
        .product_i      (product),
        .mul_done_i     (mul_done)
    );

    div_unit u_div (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (div_start),
        .signed_i   (div_signed),
        .dividend_i (div_dividend),
        .divisor_i  (div_divisor),
        .result_o   (div_result),
        .done_o     (div_done)
    );

    mul_unit u_mul (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (mul_start),
        .a_signed_i (mul_a_signed),
        .b_signed_i (mul_b_signed),
        .a_i        (mul_a),
        .b_i        (mul_b),
        .product_o  (product),
        .done_o     (mul_done)
    );

endmodule

// File: verification/muldiv_ref.svh
`ifndef MULDIV_REF_SVH
`define MULDIV_REF_SVH

// xorshift32 step, one new word per call
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// expected result word, straight from the RV32 M rules
function automatic muldiv_pkg::word_t expected_result(input muldiv_pkg::muldiv_op_e op,
                                                      input muldiv_pkg::word_t a,
                                                      input muldiv_pkg::word_t b);
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        sa;
    logic [63:0]        sb;
    logic [63:0]        prod;
    logic signed [31:0] as;
    logic signed [31:0] bs;
    logic               div_zero;
    logic               overflow;
    ua       = {32'd0, a};
    ub       = {32'd0, b};
    sa       = {{32{a[31]}}, a};  // sign extended
    sb       = {{32{b[31]}}, b};
    as       = a;
    bs       = b;
    div_zero = (b == 32'd0);
    overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
    case (op)
        muldiv_pkg::MUL: begin
            prod = ua * ub;
            return prod[31:0];
        end
        muldiv_pkg::MULH: begin
            prod = sa * sb;
            return prod[63:32];
        end
        muldiv_pkg::MULHSU: begin
            prod = sa * ub;
            return prod[63:32];
        end
        muldiv_pkg::MULHU: begin
            prod = ua * ub;
            return prod[63:32];
        end
        muldiv_pkg::DIV: begin
            if (div_zero) return 32'hFFFF_FFFF;
            if (overflow) return 32'h8000_0000;
            return as / bs;  // truncates toward zero
        end
        muldiv_pkg::DIVU: begin
            if (div_zero) return 32'hFFFF_FFFF;
            return a / b;
        end
        muldiv_pkg::REM: begin
            if (div_zero) return a;
            if (overflow) return 32'd0;
            return as % bs;  // sign of the dividend
        end
        default: begin
            if (div_zero) return a;
            return a % b;
        end
    endcase
endfunction

`endif

// File: verification/muldiv_tb.sv
`timescale 1ns/10ps
`include "muldiv_cfg.svh"

module muldiv_tb;

    logic                    clk_i;
    logic                    rst_i;
    logic                    req_i;
    muldiv_pkg::muldiv_req_t req_data_i;
    logic                    ack_o;
    muldiv_pkg::word_t       result_o;

    muldiv_pkg::muldiv_req_t sent_q[$];  // requests waiting for their ack
    string                   test_name;
    int                      tests;
    int                      checks;
    int                      errors;
    bit                      timed_out;
    logic                    ack_seen;
    logic [31:0]             seed;

    localparam muldiv_pkg::word_t udiv_a [6] = '{32'd7, 32'd12345, 32'hFFFF_FFFF,
                                                 32'd100, 32'hFFFF_FFFF, 32'hDEAD_BEEF};
    localparam muldiv_pkg::word_t udiv_b [6] = '{32'd100, 32'd1, 32'hFFFF_FFFF,
                                                 32'd7, 32'd1, 32'd1234};
    // +-7 by +-2 leaves a remainder and +-6 by +-3 does not
    localparam muldiv_pkg::word_t sdiv_a [8] = '{32'd7, 32'hFFFF_FFF9, 32'd7, 32'hFFFF_FFF9,
                                                 32'd6, 32'hFFFF_FFFA, 32'd6, 32'hFFFF_FFFA};
    localparam muldiv_pkg::word_t sdiv_b [8] = '{32'd2, 32'd2, 32'hFFFF_FFFE, 32'hFFFF_FFFE,
                                                 32'd3, 32'd3, 32'hFFFF_FFFD, 32'hFFFF_FFFD};
    localparam muldiv_pkg::word_t mul_a [6] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000,
                                                32'd0, 32'h1234_5678, 32'hFFFF_FFFE};
    localparam muldiv_pkg::word_t mul_b [6] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
                                                32'hFFFF_FFFF, 32'h9ABC_DEF0, 32'd3};

    `include "muldiv_ref.svh"

    muldiv_top dut (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .req_i      (req_i),
        .req_data_i (req_data_i),
        .ack_o      (ack_o),
        .result_o   (result_o)
    );

    always #5 clk_i = ~clk_i;

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    // results judged half a cycle after ack_o rises
    always @(negedge clk_i) begin : compare_proc
        muldiv_pkg::muldiv_req_t r;
        muldiv_pkg::muldiv_op_e  op;
        if (ack_o === 1'b1 && !ack_seen) begin
            if (sent_q.size() == 0) begin
                errors++;
                $display("ack_o rose with no request outstanding");
            end else begin
                r  = sent_q.pop_front();
                op = r.op;
                compare_word($sformatf("%s %s", test_name, op.name()),
                             expected_result(r.op, r.a, r.b), result_o);
            end
        end
        ack_seen = (ack_o === 1'b1);
    end

    // one four-phase transaction starting and ending 1 ns after a rising edge
    task automatic run_op(input muldiv_pkg::muldiv_op_e op, input muldiv_pkg::word_t a,
                          input muldiv_pkg::word_t b, input int hold);
        muldiv_pkg::word_t held;
        int                n;
        int                i;
        if (timed_out) return;
        req_data_i.op = op;
        req_data_i.a  = a;
        req_data_i.b  = b;
        sent_q.push_back(req_data_i);
        req_i = 1'b1;
        n = 0;
        while (ack_o !== 1'b1 && n < 200) begin
            @(posedge clk_i);
            #1;
            n++;
        end
        if (ack_o !== 1'b1) begin
            $display("timeout: ack_o did not rise within 200 cycles in %s", test_name);
            timed_out = 1'b1;
            req_i     = 1'b0;
            return;
        end
        held = expected_result(op, a, b);
        for (i = 0; i < hold; i++) begin  // requester stalls with req high
            @(posedge clk_i);
            #1;
            compare_word({test_name, " ack held"}, 32'd1, {31'd0, ack_o});
            compare_word({test_name, " result held"}, held, result_o);
        end
        req_i = 1'b0;
        n = 0;
        while (ack_o !== 1'b0 && n < 20) begin
            @(posedge clk_i);
            #1;
            n++;
        end
        if (ack_o !== 1'b0) begin
            $display("timeout: ack_o did not fall after req_i dropped in %s", test_name);
            timed_out = 1'b1;
        end
    endtask

    task automatic finish_test(input int errors_before);
        tests++;
        $display("test %-20s %s", test_name,
                 (errors == errors_before && !timed_out) ? "ok" : "failed");
    endtask

    initial begin
        int                     e0;
        int                     i;
        int                     k;
        muldiv_pkg::muldiv_op_e op;
        muldiv_pkg::word_t      a;
        muldiv_pkg::word_t      b;
        clk_i      = 1'b0;
        rst_i      = 1'b0;
        req_i      = 1'b0;
        req_data_i = '0;
        tests      = 0;
        checks     = 0;
        errors     = 0;
        timed_out  = 1'b0;
        ack_seen   = 1'b0;
        test_name  = "reset";
        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b1;

        test_name = "handshake";
        e0 = errors;
        compare_word({test_name, " ack after reset"}, 32'd0, {31'd0, ack_o});
        run_op(muldiv_pkg::DIVU, 32'd100, 32'd7, 5);
        run_op(muldiv_pkg::MUL, 32'd3, 32'hFFFF_FFFB, 5);
        finish_test(e0);

        test_name = "unsigned divide";
        e0 = errors;
        for (i = 0; i < 6; i++) begin
            run_op(muldiv_pkg::DIVU, udiv_a[i], udiv_b[i], 0);
            run_op(muldiv_pkg::REMU, udiv_a[i], udiv_b[i], 0);
        end
        finish_test(e0);

        test_name = "signed divide";
        e0 = errors;
        for (i = 0; i < 8; i++) begin
            run_op(muldiv_pkg::DIV, sdiv_a[i], sdiv_b[i], 0);
            run_op(muldiv_pkg::REM, sdiv_a[i], sdiv_b[i], 0);
        end
        finish_test(e0);

        test_name = "special cases";
        e0 = errors;
        for (k = 4; k < 8; k++) begin  // the four divide opcodes
            run_op(muldiv_pkg::muldiv_op_e'(k), 32'h1234_5678, 32'd0, 0);
            run_op(muldiv_pkg::muldiv_op_e'(k), 32'h8000_0000, 32'd0, 0);
        end
        run_op(muldiv_pkg::DIV, 32'h8000_0000, 32'hFFFF_FFFF, 0);
        run_op(muldiv_pkg::REM, 32'h8000_0000, 32'hFFFF_FFFF, 0);
        run_op(muldiv_pkg::DIVU, 32'h8000_0000, 32'hFFFF_FFFF, 0);
        finish_test(e0);

        test_name = "multiply";
        e0 = errors;
        for (k = 0; k < 4; k++) begin
            for (i = 0; i < 6; i++) begin
                run_op(muldiv_pkg::muldiv_op_e'(k), mul_a[i], mul_b[i], 0);
            end
        end
        finish_test(e0);

        test_name = "random mix";
        e0 = errors;
        seed = 32'h801e;
        for (i = 0; i < 300; i++) begin
            seed = xorshift32(seed);
            op   = muldiv_pkg::muldiv_op_e'(seed[2:0]);
            seed = xorshift32(seed);
            a    = seed;
            seed = xorshift32(seed);
            b    = seed;
            seed = xorshift32(seed);
            if (seed[2:0] == 3'd0) b = '0;  // zero divisor one time in eight
            run_op(op, a, b, 0);
        end
        finish_test(e0);

        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
